// ==== verilog.f ====
+incdir+sim
src/can_pkg.sv
src/can_crc15.sv
src/can_bit_timing.sv
src/can_destuffer.sv
src/can_rx_frame.sv
src/can_rx_top.sv
sim/tb_can_rx.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_can_rx -f verilog.f -o sim_can_rx
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_can_rx)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// ==== sim/can_frame_gen.svh ====
`ifndef CAN_FRAME_GEN_SVH
`define CAN_FRAME_GEN_SVH

// Raw frame bits from SOF through CRC, before stuffing
bit raw_q[$];
// Bits as they appear on the bus, stuffed and with the frame tail
bit line_q[$];
int ack_idx;

// CAN CRC-15 step, one bit, polynomial from the package
function automatic logic [14:0] crc_next(input logic [14:0] crc, input bit b);
    logic fb;
    fb = b ^ crc[14];
    crc = {crc[13:0], 1'b0};
    if (fb)
        crc = crc ^ crc_poly;
    return crc;
endfunction

function automatic int data_bytes(input logic [3:0] dlc);
    return (dlc > 4'd8) ? 8 : int'(dlc);
endfunction

// SOF, arbitration, control, data and CRC fields
function automatic void build_raw(input logic [28:0] id, input bit ext, input bit r,
                                  input logic [3:0] dlc, input logic [63:0] data,
                                  input bit flip_crc);
    logic [14:0] crc;
    int          nb;
    raw_q.delete();
    raw_q.push_back(1'b0);                      // SOF
    for (int i = 28; i >= 18; i--)
        raw_q.push_back(id[i]);
    if (ext) begin
        raw_q.push_back(1'b1);                  // SRR
        raw_q.push_back(1'b1);                  // IDE
        for (int i = 17; i >= 0; i--)
            raw_q.push_back(id[i]);
        raw_q.push_back(r);
        raw_q.push_back(1'b0);                  // r1
        raw_q.push_back(1'b0);                  // r0
    end else begin
        raw_q.push_back(r);
        raw_q.push_back(1'b0);                  // IDE
        raw_q.push_back(1'b0);                  // r0
    end
    for (int i = 3; i >= 0; i--)
        raw_q.push_back(dlc[i]);
    nb = r ? 0 : data_bytes(dlc);
    for (int i = 8 * nb - 1; i >= 0; i--)
        raw_q.push_back(data[i]);
    crc = '0;
    foreach (raw_q[i])
        crc = crc_next(crc, raw_q[i]);
    if (flip_crc)
        crc[0] = ~crc[0];
    for (int i = 14; i >= 0; i--)
        raw_q.push_back(crc[i]);
endfunction

// Stuff bit goes in ahead of the next field bit, never after the last CRC bit
function automatic void stuff_and_close();
    int run;
    bit last;
    run  = 0;
    last = 1'b1;
    line_q.delete();
    foreach (raw_q[i]) begin
        if (run == stuff_limit) begin
            line_q.push_back(~last);
            last = ~last;
            run  = 1;
        end
        line_q.push_back(raw_q[i]);
        if (raw_q[i] == last) begin
            run++;
        end else begin
            run  = 1;
            last = raw_q[i];
        end
    end
    line_q.push_back(1'b1);                     // CRC delimiter
    ack_idx = line_q.size();
    line_q.push_back(1'b1);                     // ACK slot, left recessive
    line_q.push_back(1'b1);                     // ACK delimiter
    repeat (eof_bits + intermission_bits)
        line_q.push_back(1'b1);
endfunction

`endif

// ==== sim/tb_can_rx.sv ====
module tb_can_rx;
    timeunit 1ns;
    timeprecision 100ps;
    import can_pkg::*;

    logic        clk;
    logic        rst;
    logic        bus_lvl;
    logic        rx_raw;
    logic        tx;
    logic [28:0] msg_id;
    logic        rtr;
    logic        extended;
    logic [63:0] msg;
    logic [3:0]  msg_bytes;
    logic        msg_fresh;
    logic        bus_idle;
    logic        form_error;
    logic        overload_error;

    logic [31:0] seed;
    logic [28:0] exp_id;
    logic        exp_rtr;
    logic        exp_ext;
    logic [3:0]  exp_bytes;
    logic [63:0] exp_msg;
    logic        frame_good;   // Frame under test should be accepted
    logic        ack_window;   // ACK slot and its delimiter on the bus
    logic        form_q;
    int          fresh_cnt;
    int          form_cnt;
    int          ack_cnt;
    int          errors;
    int          tests;
    int          passed;

    `include "can_frame_gen.svh"

    assign rx_raw = bus_lvl & tx;   // Wired-AND bus

    can_rx_top uut (
        .clk            (clk),
        .rst            (rst),
        .rx_raw         (rx_raw),
        .tx             (tx),
        .msg_id         (msg_id),
        .rtr            (rtr),
        .extended       (extended),
        .msg            (msg),
        .msg_bytes      (msg_bytes),
        .msg_fresh      (msg_fresh),
        .bus_idle       (bus_idle),
        .form_error     (form_error),
        .overload_error (overload_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Event counters for the end-of-frame checks
    always @(posedge clk) begin
        form_q <= form_error;
        if (msg_fresh)
            fresh_cnt <= fresh_cnt + 1;
        if (form_error && !form_q)
            form_cnt <= form_cnt + 1;
        if (!tx)
            ack_cnt <= ack_cnt + 1;
    end

    a_fresh_ok: assert property (@(posedge clk) disable iff (rst) msg_fresh |-> frame_good)
        else begin
            $display("msg_fresh pulsed for a frame that should be rejected");
            errors++;
        end
    a_id: assert property (@(posedge clk) disable iff (rst) msg_fresh |-> msg_id == exp_id)
        else begin
            $display("mismatch msg_id: expected %h, got %h", exp_id, msg_id);
            errors++;
        end
    a_rtr: assert property (@(posedge clk) disable iff (rst) msg_fresh |-> rtr == exp_rtr)
        else begin
            $display("mismatch rtr: expected %h, got %h", exp_rtr, rtr);
            errors++;
        end
    a_ext: assert property (@(posedge clk) disable iff (rst)
        msg_fresh |-> extended == exp_ext)
        else begin
            $display("mismatch extended: expected %h, got %h", exp_ext, extended);
            errors++;
        end
    a_bytes: assert property (@(posedge clk) disable iff (rst)
        msg_fresh |-> msg_bytes == exp_bytes)
        else begin
            $display("mismatch msg_bytes: expected %h, got %h", exp_bytes, msg_bytes);
            errors++;
        end
    a_msg: assert property (@(posedge clk) disable iff (rst) msg_fresh |-> msg == exp_msg)
        else begin
            $display("mismatch msg: expected %h, got %h", exp_msg, msg);
            errors++;
        end
    // Dominant drive only inside the ACK slot of an accepted frame
    a_tx: assert property (@(posedge clk) disable iff (rst) !tx |-> ack_window && frame_good)
        else begin
            $display("tx dominant outside the ACK slot of a good frame");
            errors++;
        end
    // A good frame never sees an overload condition
    a_ovl: assert property (@(posedge clk) disable iff (rst) frame_good |-> !overload_error)
        else begin
            $display("mismatch overload_error: expected %h, got %h", 1'b0, overload_error);
            errors++;
        end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic drive_bits();
        foreach (line_q[i]) begin
            @(negedge clk);
            bus_lvl    = line_q[i];
            ack_window = (i == ack_idx) || (i == ack_idx + 1);
            repeat (bit_quanta - 1) @(negedge clk);
        end
        @(negedge clk);
        ack_window = 1'b0;
        bus_lvl    = 1'b1;
    endtask

    task automatic wait_bus_idle();
        int n;
        n = 0;
        while (!bus_idle && n < 200 * bit_quanta) begin
            @(negedge clk);
            n++;
        end
        repeat (bit_quanta) @(negedge clk);  // One idle bit between frames
        if (!bus_idle) begin
            $display("timeout: bus_idle did not return high within 200 bit times");
            $display("Errors found");
            $finish;
        end
    endtask

    task automatic run_test(input string name, input logic [28:0] id, input bit ext,
                            input bit r, input logic [3:0] dlc, input logic [63:0] data,
                            input bit flip_crc, input bit inject, input bit good);
        int          errs_before;
        int          fresh_before;
        int          form_before;
        int          ack_before;
        int          nb;
        logic [63:0] mask;
        errs_before  = errors;
        fresh_before = fresh_cnt;
        form_before  = form_cnt;
        ack_before   = ack_cnt;
        nb   = r ? 0 : data_bytes(dlc);
        mask = (nb == 8) ? '1 : ((64'd1 << (8 * nb)) - 64'd1);
        exp_id     = ext ? id : {id[28:18], 18'd0};
        exp_rtr    = r;
        exp_ext    = ext;
        exp_bytes  = 4'(data_bytes(dlc));
        exp_msg    = data & mask;
        frame_good = good;
        build_raw(id, ext, r, dlc, data & mask, flip_crc);
        stuff_and_close();
        if (inject) begin
            for (int i = 1; i <= 6; i++)
                line_q[i] = 1'b1;   // Six recessive bits right after SOF
        end
        drive_bits();
        wait_bus_idle();
        if (good) begin
            assert (fresh_cnt == fresh_before + 1)
                else begin
                    $display("no single msg_fresh pulse for a good frame");
                    errors++;
                end
            assert (ack_cnt > ack_before)
                else begin
                    $display("tx was never dominant in the ACK slot");
                    errors++;
                end
        end else begin
            assert (form_cnt > form_before)
                else begin
                    $display("form_error never rose for a bad frame");
                    errors++;
                end
            assert (fresh_cnt == fresh_before)
                else begin
                    $display("msg_fresh pulsed for a bad frame");
                    errors++;
                end
        end
        tests++;
        if (errors == errs_before) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail", name);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        seed       = 32'h3abc_d6cb;
        rst        = 1'b1;
        bus_lvl    = 1'b1;
        ack_window = 1'b0;
        frame_good = 1'b1;
        exp_id     = '0;
        exp_rtr    = 1'b0;
        exp_ext    = 1'b0;
        exp_bytes  = '0;
        exp_msg    = '0;
        form_q     = 1'b0;
        fresh_cnt  = 0;
        form_cnt   = 0;
        ack_cnt    = 0;
        errors     = 0;
        tests      = 0;
        passed     = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3 * bit_quanta) @(negedge clk);

        a = lcg_next();
        b = lcg_next();
        run_test("standard", {a[10:0], 18'd0}, 1'b0, 1'b0, 4'(1 + a[20:18] % 8),
                 {a, b}, 1'b0, 1'b0, 1'b1);
        a = lcg_next();
        b = lcg_next();
        run_test("extended", 29'(lcg_next()), 1'b1, 1'b0, 4'd12, {a, b},
                 1'b0, 1'b0, 1'b1);
        run_test("remote", {11'(lcg_next()), 18'd0}, 1'b0, 1'b1, 4'd5, '0,
                 1'b0, 1'b0, 1'b1);
        a = lcg_next();
        run_test("bad_crc", {a[10:0], 18'd0}, 1'b0, 1'b0, 4'd3, {a, a},
                 1'b1, 1'b0, 1'b0);
        a = lcg_next();
        run_test("stuff_error", {a[10:0], 18'd0}, 1'b0, 1'b0, 4'd2, {a, a},
                 1'b0, 1'b1, 1'b0);
        a = lcg_next();
        b = lcg_next();
        run_test("after_error", {b[10:0], 18'd0}, 1'b0, 1'b0, 4'd8, {a, b},
                 1'b0, 1'b0, 1'b1);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src/can_rx_top.sv ====
module can_rx_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rx_raw,
    output logic                        tx,
    output logic [can_pkg::id_w-1:0]    msg_id,
    output logic                        rtr,
    output logic                        extended,
    output logic [can_pkg::data_w-1:0]  msg,
    output logic [can_pkg::dlc_w-1:0]   msg_bytes,
    output logic                        msg_fresh,
    output logic                        bus_idle,
    output logic                        form_error,
    output logic                        overload_error
);

    logic sample_bit;
    logic sample_tick;
    logic sync_tick;
    logic bit_valid;
    logic bit_value;
    logic stuff_error;
    logic destuff_off;

    can_bit_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .rx_raw      (rx_raw),
        .tx          (tx),
        .bus_idle    (bus_idle),
        .sample_bit  (sample_bit),
        .sample_tick (sample_tick),
        .sync_tick   (sync_tick)
    );

    can_destuffer u_destuff (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .sample_bit  (sample_bit),
        .destuff_off (destuff_off),
        .bit_valid   (bit_valid),
        .bit_value   (bit_value),
        .stuff_error (stuff_error)
    );

    can_rx_frame u_frame (
        .clk            (clk),
        .rst            (rst),
        .bit_valid      (bit_valid),
        .bit_value      (bit_value),
        .stuff_error    (stuff_error),
        .sync_tick      (sync_tick),
        .msg_id         (msg_id),
        .rtr            (rtr),
        .extended       (extended),
        .msg            (msg),
        .msg_bytes      (msg_bytes),
        .msg_fresh      (msg_fresh),
        .bus_idle       (bus_idle),
        .destuff_off    (destuff_off),
        .tx             (tx),
        .form_error     (form_error),
        .overload_error (overload_error)
    );

endmodule

// ==== src/can_rx_frame.sv ====
module can_rx_frame (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        bit_valid,
    input  logic                        bit_value,
    input  logic                        stuff_error,
    input  logic                        sync_tick,
    output logic [can_pkg::id_w-1:0]    msg_id,
    output logic                        rtr,
    output logic                        extended,
    output logic [can_pkg::data_w-1:0]  msg,
    output logic [can_pkg::dlc_w-1:0]   msg_bytes,
    output logic                        msg_fresh,
    output logic                        bus_idle,
    output logic                        destuff_off,
    output logic                        tx,
    output logic                        form_error,
    output logic                        overload_error
);
    import can_pkg::*;

    rx_state_e        state;
    logic [5:0]       cnt;          // Bit index or bit count, per field
    logic [dlc_w-1:1] dlc_hi;
    logic [dlc_w-1:0] dlc_full;
    logic [dlc_w-1:0] dlc_capped;
    logic [crc_w-1:0] crc_rx;
    logic [crc_w-1:0] crc_value;
    logic             ack_arm;
    logic             crc_bad;
    logic             sof;
    logic             crc_en;
    logic             crc_clr;

    assign dlc_full   = {dlc_hi, bit_value};
    assign dlc_capped = (dlc_full > dlc_w'(max_bytes)) ? dlc_w'(max_bytes) : dlc_full;

    // Start of frame from idle, or from the last intermission bit
    assign sof = bit_valid && !bit_value &&
                 (state == st_idle ||
                  (state == st_intermission && cnt == 6'(intermission_bits - 1)));

    assign destuff_off = !(state inside {[st_id:st_crc]});
    assign crc_en      = sof || (bit_valid && state inside {[st_id:st_data]});
    assign crc_clr     = state inside {st_eof, st_error_flag, st_error_delim};

    can_crc15 u_crc (
        .clk       (clk),
        .rst       (rst),
        .crc_clr   (crc_clr),
        .crc_en    (crc_en),
        .crc_bit   (bit_value),
        .crc_value (crc_value)
    );

    // Message fields
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            msg_id    <= '0;
            msg       <= '0;
            rtr       <= 1'b0;
            extended  <= 1'b0;
            msg_bytes <= '0;
            dlc_hi    <= '0;
            crc_rx    <= '0;
        end else if (sof) begin
            msg_id   <= '0;
            msg      <= '0;
            rtr      <= 1'b0;
            extended <= 1'b0;
        end else if (bit_valid) begin
            case (state)
                st_id:      msg_id[cnt[4:0]] <= bit_value;
                st_rtr_srr: rtr <= bit_value;
                st_ide:     extended <= bit_value;
                st_dlc: begin
                    if (cnt == 6'd0)
                        msg_bytes <= dlc_capped;
                    else
                        dlc_hi[cnt[1:0]] <= bit_value;
                end
                st_data:    msg[cnt] <= bit_value;  // MSB first
                st_crc:     crc_rx[cnt[3:0]] <= bit_value;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= st_idle;
            cnt            <= '0;
            bus_idle       <= 1'b1;
            msg_fresh      <= 1'b0;
            tx             <= 1'b1;
            form_error     <= 1'b0;
            overload_error <= 1'b0;
            ack_arm        <= 1'b0;
            crc_bad        <= 1'b0;
        end else begin
            msg_fresh <= 1'b0;

            if (sync_tick)
                tx <= !(ack_arm && state == st_ack_slot);  // Whole bit time on the bus

            if (stuff_error) begin
                form_error <= 1'b1;
                ack_arm    <= 1'b0;
                state      <= st_error_flag;
            end else if (sof) begin
                state          <= st_id;
                cnt            <= 6'(id_w - 1);
                bus_idle       <= 1'b0;
                form_error     <= 1'b0;
                overload_error <= 1'b0;
                crc_bad        <= 1'b0;
            end else if (bit_valid) begin
                case (state)
                    st_id: begin
                        cnt <= cnt - 6'd1;
                        // Base part ends at bit 18, extended part at bit 0
                        if (cnt == 6'(id_w - 11) || cnt == 6'd0)
                            state <= st_rtr_srr;
                    end
                    st_rtr_srr: begin
                        if (extended) begin
                            state <= st_reserved;   // r1 and r0
                            cnt   <= 6'd2;
                        end else begin
                            state <= st_ide;
                        end
                    end
                    st_ide: begin
                        if (bit_value) begin
                            state <= st_id;         // Index carries on at 17
                        end else begin
                            state <= st_reserved;   // r0 only
                            cnt   <= 6'd1;
                        end
                    end
                    st_reserved: begin
                        cnt <= cnt - 6'd1;
                        if (cnt == 6'd1) begin
                            state <= st_dlc;
                            cnt   <= 6'(dlc_w - 1);
                        end
                    end
                    st_dlc: begin
                        if (cnt != 6'd0) begin
                            cnt <= cnt - 6'd1;
                        end else if (rtr || dlc_capped == '0) begin
                            state <= st_crc;
                            cnt   <= 6'(crc_w - 1);
                        end else begin
                            state <= st_data;
                            cnt   <= {3'(dlc_capped - 4'd1), 3'b111};  // 8*bytes-1
                        end
                    end
                    st_data: begin
                        cnt <= cnt - 6'd1;
                        if (cnt == 6'd0) begin
                            state <= st_crc;
                            cnt   <= 6'(crc_w - 1);
                        end
                    end
                    st_crc: begin
                        cnt <= cnt - 6'd1;
                        if (cnt == 6'd0)
                            state <= st_crc_delim;
                    end
                    st_crc_delim: begin
                        if (!bit_value) begin
                            form_error <= 1'b1;
                            state      <= st_error_flag;
                        end else begin
                            ack_arm <= (crc_rx == crc_value);
                            crc_bad <= (crc_rx != crc_value);
                            state   <= st_ack_slot;
                        end
                    end
                    st_ack_slot: begin
                        ack_arm <= 1'b0;
                        state   <= st_ack_delim;
                    end
                    st_ack_delim: begin
                        if (!bit_value || crc_bad) begin
                            form_error <= 1'b1;
                            state      <= st_error_flag;
                        end else begin
                            state <= st_eof;
                            cnt   <= '0;
                        end
                    end
                    st_eof: begin
                        if (!bit_value) begin
                            form_error <= 1'b1;
                            state      <= st_error_flag;
                        end else begin
                            cnt <= cnt + 6'd1;
                            if (cnt == 6'(eof_bits - 2))
                                msg_fresh <= 1'b1;  // Message valid after the sixth EOF bit
                            if (cnt == 6'(eof_bits - 1)) begin
                                state <= st_intermission;
                                cnt   <= '0;
                            end
                        end
                    end
                    st_intermission: begin
                        if (!bit_value) begin
                            overload_error <= 1'b1;
                            state          <= st_error_flag;
                        end else if (cnt == 6'(intermission_bits - 1)) begin
                            state    <= st_idle;
                            bus_idle <= 1'b1;
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                    st_error_flag: begin
                        // First recessive bit is delimiter bit one
                        if (bit_value) begin
                            state <= st_error_delim;
                            cnt   <= 6'd1;
                        end
                    end
                    st_error_delim: begin
                        if (!bit_value) begin
                            state <= st_error_flag;
                        end else if (cnt == 6'(error_delim_bits - 1)) begin
                            form_error     <= 1'b0;
                            overload_error <= 1'b0;
                            state          <= st_intermission;
                            cnt            <= '0;
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Dominant drive stays within the ACK slot bit, which ends in st_ack_delim
    a_ack_only: assert property (@(posedge clk) disable iff (rst)
        !tx |-> state inside {st_ack_slot, st_ack_delim})
        else $error("tx dominant outside the ACK slot");

endmodule

// ==== src/can_destuffer.sv ====
module can_destuffer (
    input  logic clk,
    input  logic rst,
    input  logic sample_tick,
    input  logic sample_bit,
    input  logic destuff_off,
    output logic bit_valid,
    output logic bit_value,
    output logic stuff_error
);
    import can_pkg::*;

    logic [2:0] run_cnt;    // Length of the current run of equal bits
    logic       last_bit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_valid   <= 1'b0;
            bit_value   <= 1'b1;
            stuff_error <= 1'b0;
            run_cnt     <= '0;
            last_bit    <= 1'b1;
        end else begin
            bit_valid   <= 1'b0;
            stuff_error <= 1'b0;
            if (sample_tick) begin
                if (destuff_off) begin
                    bit_valid <= 1'b1;
                    bit_value <= sample_bit;
                    run_cnt   <= 3'd1;       // History restarts with this bit
                    last_bit  <= sample_bit;
                end else if (run_cnt == 3'(stuff_limit)) begin
                    if (sample_bit == last_bit) begin
                        stuff_error <= 1'b1; // Sixth equal bit
                        run_cnt     <= '0;
                    end else begin
                        // Stuff bit dropped, but it opens the next run
                        run_cnt  <= 3'd1;
                        last_bit <= sample_bit;
                    end
                end else begin
                    bit_valid <= 1'b1;
                    bit_value <= sample_bit;
                    last_bit  <= sample_bit;
                    run_cnt   <= (sample_bit == last_bit) ? run_cnt + 3'd1 : 3'd1;
                end
            end
        end
    end

    // Each output pulse answers exactly one sample, and only one kind fires
    a_one_result: assert property (@(posedge clk) disable iff (rst)
        (bit_valid || stuff_error) |-> !(bit_valid && stuff_error) && $past(sample_tick))
        else $error("destuffer output without a sample or with both flags");

endmodule

// ==== src/can_bit_timing.sv ====
module can_bit_timing (
    input  logic clk,
    input  logic rst,
    input  logic rx_raw,
    input  logic tx,
    input  logic bus_idle,
    output logic sample_bit,
    output logic sample_tick,
    output logic sync_tick
);
    import can_pkg::*;

    logic [8:0] q;              // Quantum within the current bit
    logic       last_rx;
    logic       yet_to_resync;
    logic       fall;
    logic       wrap;
    logic       in_window;
    logic       hard_sync;
    logic       resync;
    logic       restart;
    logic       at_sample;

    // Only bus edges that our own ACK did not cause
    assign fall      = last_rx && !rx_raw && tx;
    assign wrap      = (q == bit_quanta - 9'd1);
    assign in_window = (q < 9'(sjw_q)) || (q > bit_quanta - 9'd1 - 9'(sjw_q));
    assign hard_sync = fall && bus_idle;
    assign resync    = fall && !bus_idle && yet_to_resync && in_window && !wrap;
    assign restart   = wrap || hard_sync || resync;
    assign at_sample = (q == 9'(prop_seg_q) + 9'(phase1_q) + 9'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q             <= '0;
            last_rx       <= 1'b1;
            yet_to_resync <= 1'b1;
            sample_bit    <= 1'b1;
            sample_tick   <= 1'b0;
            sync_tick     <= 1'b0;
        end else begin
            last_rx     <= rx_raw;
            q           <= restart ? 9'd0 : q + 9'd1;
            sync_tick   <= restart;
            sample_tick <= at_sample && !restart;

            if (at_sample && !restart)
                sample_bit <= rx_raw;

            // One resync per bit; a hard sync or a full bit rearms it
            if (resync)
                yet_to_resync <= 1'b0;
            else if (wrap || hard_sync)
                yet_to_resync <= 1'b1;
        end
    end

    // Samples are a bit apart and never land on a bit start
    a_tick_spacing: assert property (@(posedge clk) disable iff (rst)
        sample_tick |-> !sync_tick && !$past(sample_tick))
        else $error("sample_tick overlaps sync_tick or repeats");

endmodule

// ==== src/can_crc15.sv ====
module can_crc15 (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       crc_clr,
    input  logic                       crc_en,
    input  logic                       crc_bit,
    output logic [can_pkg::crc_w-1:0]  crc_value
);
    import can_pkg::*;

    logic feedback;

    assign feedback = crc_bit ^ crc_value[crc_w-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_value <= '0;
        end else if (crc_clr) begin
            crc_value <= '0;
        end else if (crc_en) begin
            // Shift left, fold in the polynomial on a mismatch
            crc_value <= {crc_value[crc_w-2:0], 1'b0} ^ (feedback ? crc_poly : '0);
        end
    end

endmodule

// ==== src/can_pkg.sv ====
package can_pkg;

    // Bit timing in clock quanta
    localparam logic [6:0] prop_seg_q = 7'd18;
    localparam logic [6:0] phase1_q   = 7'd40;
    localparam logic [6:0] phase2_q   = 7'd40;
    localparam logic [8:0] bit_quanta = 9'(prop_seg_q) + 9'(phase1_q) + 9'(phase2_q) + 9'd1;
    localparam logic [6:0] sjw_q      = 7'd5;  // Resync jump width

    // Frame field widths
    localparam int id_w   = 29;
    localparam int data_w = 64;
    localparam int dlc_w  = 4;
    localparam int crc_w  = 15;

    localparam logic [crc_w-1:0] crc_poly = 15'h4599;

    localparam int max_bytes   = 8;  // DLC values above this still carry 8 bytes
    localparam int stuff_limit = 5;

    localparam int eof_bits          = 7;
    localparam int intermission_bits = 3;
    localparam int error_delim_bits  = 8;

    typedef enum logic [3:0] {
        st_idle,
        st_id,
        st_rtr_srr,       // SRR on first pass of an extended frame
        st_ide,
        st_reserved,
        st_dlc,
        st_data,
        st_crc,
        st_crc_delim,
        st_ack_slot,
        st_ack_delim,
        st_eof,
        st_intermission,
        st_error_flag,
        st_error_delim
    } rx_state_e;

endpackage
